/* sdmac_pkg.sv */
package sdmac_pkg;

  // CPU register map, byte addresses on addr[7:0]
  localparam logic [7:0] ADDR_WTC     = 8'h04;
  localparam logic [7:0] ADDR_CNTR    = 8'h08;
  localparam logic [7:0] ADDR_ACR     = 8'h0C;
  localparam logic [7:0] ADDR_ST_DMA  = 8'h10;
  localparam logic [7:0] ADDR_FLUSH   = 8'h14;
  localparam logic [7:0] ADDR_CLR_INT = 8'h18;
  localparam logic [7:0] ADDR_ISTR    = 8'h1C;
  localparam logic [7:0] ADDR_SP_DMA  = 8'h3C;
  localparam logic [2:0] WIN_PAGE     = 3'b010; // addr[7:5], 0x40..0x5F

  // Decoded register functions
  typedef enum logic [3:0] {
    SEL_NONE,
    SEL_WTC,
    SEL_CNTR,
    SEL_ACR,
    SEL_ST_DMA,
    SEL_FLUSH,
    SEL_CLR_INT,
    SEL_ISTR,
    SEL_SP_DMA,
    SEL_WINDOW
  } reg_sel_e;

  // Control register
  localparam int CNTR_W      = 9;
  localparam int CNTR_TCEN   = 5; // Transfer count enable
  localparam int CNTR_PRESET = 4; // Peripheral reset
  localparam int CNTR_INTEN  = 2; // Interrupt enable
  localparam int CNTR_DDIR   = 1; // 1 = memory to SCSI

  // Interrupt status register
  localparam int ISTR_W     = 9;
  localparam int ISTR_INT_F = 8; // Interrupt being driven
  localparam int ISTR_INTS  = 7; // Latched SCSI interrupt
  localparam int ISTR_E_INT = 6; // DMA stopped
  localparam int ISTR_FE    = 1; // FIFO empty, live
  localparam int ISTR_FF    = 0; // FIFO full, live

  localparam logic [31:0] WTC_VALUE = 32'h4; // No real counter behind it

  // Peripheral bus timing
  localparam int unsigned P_CYCLE    = 4;      // Clocks per access
  localparam logic [4:0]  DATA_PORT  = 5'h19;  // SCSI chip data register
  localparam int unsigned TERM_DELAY = 2;      // AS sample to DSACK, local regs

  typedef enum logic [1:0] {ARB_IDLE, ARB_BUSY, ARB_DONE} arb_state_e;
  typedef enum logic [1:0] {DMA_IDLE, DMA_REQ, DMA_FIFO} dma_state_e;

endpackage

/* periph_req_if.sv */
`timescale 1ns/1ps

// One requester's view of the shared peripheral bus
interface periph_req_if;

  logic       req;   // Held until done
  logic       we;    // 1 = write
  logic [4:0] addr;  // Peripheral register
  logic [7:0] wdata;
  logic [7:0] rdata; // Captured in the last strobe cycle
  logic       done;  // One cycle pulse, ends the access

  modport requester (
    output req,
    output we,
    output addr,
    output wdata,
    input  rdata,
    input  done
  );

  modport arbiter (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output rdata,
    output done
  );

endinterface

/* addr_decoder.sv */
`timescale 1ns/1ps

module addr_decoder import sdmac_pkg::*; (
  input  logic                   CLK,
  input  logic                   CLR_FLUSHFIFO,
  input  logic [7:0]             addr,
  input  logic                   dmac_n,    // Chip select
  input  logic                   as_n,      // CPU address strobe
  input  logic                   rw,        // 1 = read
  input  logic [7:0]             mid_low,   // Write data for the window
  output reg_sel_e               sel,
  output logic                   wr_stb,
  output logic                   rd_act,
  periph_req_if.requester        win,
  output logic                   reg_dsk_n
);

  localparam int CW = $clog2(TERM_DELAY + 1);

  reg_sel_e      dec_sel;
  logic          start;     // First sampled cycle of a CPU access
  logic          active;    // Access in progress
  logic          local_q;   // Local register access, fixed termination
  logic          term_q;    // Termination reached
  logic [CW-1:0] term_cnt;
  logic          is_action;

  always_comb begin
    dec_sel = SEL_NONE;
    if (addr[7:5] == WIN_PAGE) begin
      dec_sel = SEL_WINDOW;
    end else begin
      case (addr)
        ADDR_WTC:     dec_sel = SEL_WTC;
        ADDR_CNTR:    dec_sel = SEL_CNTR;
        ADDR_ACR:     dec_sel = SEL_ACR;
        ADDR_ST_DMA:  dec_sel = SEL_ST_DMA;
        ADDR_FLUSH:   dec_sel = SEL_FLUSH;
        ADDR_CLR_INT: dec_sel = SEL_CLR_INT;
        ADDR_ISTR:    dec_sel = SEL_ISTR;
        ADDR_SP_DMA:  dec_sel = SEL_SP_DMA;
        default:      dec_sel = SEL_NONE;
      endcase
    end
  end

  // Action addresses strobe on reads as well as writes
  assign is_action = (dec_sel == SEL_ST_DMA) || (dec_sel == SEL_SP_DMA) ||
                     (dec_sel == SEL_CLR_INT) || (dec_sel == SEL_FLUSH);
  assign start = !as_n && !dmac_n && !active && !win.req;

  always_ff @(posedge CLK or negedge CLR_FLUSHFIFO) begin
    if (!CLR_FLUSHFIFO) begin
      sel      <= SEL_NONE;
      wr_stb   <= 1'b0;
      rd_act   <= 1'b0;
      active   <= 1'b0;
      local_q  <= 1'b0;
      term_q   <= 1'b0;
      term_cnt <= '0;
      win.req  <= 1'b0;
    end else begin
      wr_stb <= 1'b0; // Single pulse
      if (start) begin
        active   <= 1'b1;
        sel      <= dec_sel;
        rd_act   <= rw;
        term_cnt <= '0;
        local_q  <= (dec_sel != SEL_WINDOW);
        wr_stb   <= (dec_sel != SEL_WINDOW) && (!rw || is_action);
        win.req  <= (dec_sel == SEL_WINDOW);
      end else if (as_n) begin // CPU ended the cycle
        active  <= 1'b0;
        sel     <= SEL_NONE;
        rd_act  <= 1'b0;
        local_q <= 1'b0;
        term_q  <= 1'b0;
      end else if (active && local_q && !term_q) begin
        // DSACK at the TERM_DELAY-th edge after the sampling edge
        if (term_cnt == CW'(TERM_DELAY - 1)) term_q <= 1'b1;
        else term_cnt <= term_cnt + 1'b1;
      end
      if (win.req && win.done) begin
        win.req <= 1'b0;
        if (!as_n) term_q <= 1'b1; // Window terminates after the grant
      end
    end
  end

  // Window payload, captured once per access
  always_ff @(posedge CLK) begin
    if (start && dec_sel == SEL_WINDOW) begin
      win.we    <= !rw;
      win.addr  <= addr[4:0];
      win.wdata <= mid_low;
    end
  end

  assign reg_dsk_n = as_n | ~term_q; // Released with AS, no extra cycle

endmodule

/* istr_reg.sv */
`timescale 1ns/1ps

module istr_reg import sdmac_pkg::*; (
  input  logic              CLK,
  input  logic              CLR_FLUSHFIFO,
  input  logic              fifo_empty,
  input  logic              fifo_full,
  input  logic              scsi_int,  // Level from the SCSI chip
  input  logic              clr_int,   // Clear strobe
  input  logic              dma_stop,  // Stop DMA strobe
  input  logic              inten,     // CNTR interrupt enable
  output logic [ISTR_W-1:0] istr,
  output logic              int_n
);

  logic ints;   // Latched SCSI interrupt
  logic e_int;  // End of DMA
  logic int_f;

  // Set beats clear in the same cycle
  always_ff @(posedge CLK or negedge CLR_FLUSHFIFO) begin
    if (!CLR_FLUSHFIFO) begin
      ints <= 1'b0;
    end else if (scsi_int) begin
      ints <= 1'b1;
    end else if (clr_int) begin
      ints <= 1'b0;
    end
  end

  always_ff @(posedge CLK or negedge CLR_FLUSHFIFO) begin
    if (!CLR_FLUSHFIFO) begin
      e_int <= 1'b0;
    end else if (dma_stop) begin
      e_int <= 1'b1;
    end else if (clr_int) begin
      e_int <= 1'b0;
    end
  end

  assign int_f = inten & (ints | e_int);
  assign int_n = ~int_f; // Open-drain style, low = request

  always_comb begin
    istr             = '0;  // Unused bits read as 0
    istr[ISTR_INT_F] = int_f;
    istr[ISTR_INTS]  = ints;
    istr[ISTR_E_INT] = e_int;
    istr[ISTR_FE]    = fifo_empty;  // Live flags
    istr[ISTR_FF]    = fifo_full;
  end

endmodule

/* cntr_reg.sv */
`timescale 1ns/1ps

module cntr_reg import sdmac_pkg::*; (
  input  logic              CLK,
  input  logic              CLR_FLUSHFIFO,
  input  logic              cntr_wr,
  input  logic              acr_wr,
  input  logic              st_dma,
  input  logic              sp_dma,
  input  logic              flush,
  input  logic              stop_flush,
  input  logic [CNTR_W-1:0] mid,
  input  logic              mid_a1,     // Data bit 25 on an ACR write
  output logic [CNTR_W-1:0] cntr,
  output logic              dmaena,
  output logic              flushfifo,
  output logic              a1
);

  // All 9 bits stored, fields picked out at the top
  always_ff @(posedge CLK or negedge CLR_FLUSHFIFO) begin
    if (!CLR_FLUSHFIFO) begin
      cntr <= '0;
    end else if (cntr_wr) begin
      cntr <= mid;
    end
  end

  always_ff @(posedge CLK or negedge CLR_FLUSHFIFO) begin
    if (!CLR_FLUSHFIFO) begin
      a1 <= 1'b0;
    end else if (acr_wr) begin
      a1 <= mid_a1; // Feeds the FIFO byte pointer
    end
  end

  // DMA enable, stop wins
  always_ff @(posedge CLK or negedge CLR_FLUSHFIFO) begin
    if (!CLR_FLUSHFIFO) begin
      dmaena <= 1'b0;
    end else if (sp_dma) begin
      dmaena <= 1'b0;
    end else if (st_dma) begin
      dmaena <= 1'b1;
    end
  end

  always_ff @(posedge CLK or negedge CLR_FLUSHFIFO) begin
    if (!CLR_FLUSHFIFO) begin
      flushfifo <= 1'b0;
    end else if (stop_flush) begin
      flushfifo <= 1'b0; // FIFO reports flush complete
    end else if (flush) begin
      flushfifo <= 1'b1;
    end
  end

endmodule

/* periph_arbiter.sv */
`timescale 1ns/1ps

module periph_arbiter import sdmac_pkg::*; (
  input  logic         CLK,
  input  logic         CLR_FLUSHFIFO,
  periph_req_if.arbiter cpu,
  periph_req_if.arbiter dma,
  output logic [4:0]   p_addr,
  output logic [7:0]   p_wdata,
  output logic         p_cs_n,
  output logic         p_rd_n,
  output logic         p_wr_n,
  input  logic [7:0]   p_rdata
);

  localparam int CW = $clog2(P_CYCLE);

  arb_state_e    state;
  logic [CW-1:0] cyc_cnt;
  logic          owner_dma;  // Owner of the running cycle
  logic          last_dma;   // Last grant went to DMA
  logic          pick_cpu;
  logic          pick_dma;
  logic          last_cyc;

  // Round robin between two, the loser of the last grant goes first
  assign pick_cpu = cpu.req && (!dma.req || last_dma);
  assign pick_dma = dma.req && !pick_cpu;
  assign last_cyc = (state == ARB_BUSY) && (cyc_cnt == CW'(P_CYCLE - 1));

  always_ff @(posedge CLK or negedge CLR_FLUSHFIFO) begin
    if (!CLR_FLUSHFIFO) begin
      state     <= ARB_IDLE;
      cyc_cnt   <= '0;
      owner_dma <= 1'b0;
      last_dma  <= 1'b0;
      p_cs_n    <= 1'b1;
      p_rd_n    <= 1'b1;
      p_wr_n    <= 1'b1;
      cpu.done  <= 1'b0;
      dma.done  <= 1'b0;
    end else begin
      case (state)
        ARB_IDLE: if (pick_cpu || pick_dma) begin
          owner_dma <= pick_dma;
          last_dma  <= pick_dma;
          cyc_cnt   <= '0;
          p_cs_n    <= 1'b0;
          p_rd_n    <= pick_dma ? dma.we : cpu.we;   // Strobes span the whole cycle
          p_wr_n    <= pick_dma ? !dma.we : !cpu.we;
          state     <= ARB_BUSY;
        end
        ARB_BUSY: if (last_cyc) begin
          p_cs_n   <= 1'b1;
          p_rd_n   <= 1'b1;
          p_wr_n   <= 1'b1;
          cpu.done <= !owner_dma;
          dma.done <= owner_dma;
          state    <= ARB_DONE;
        end else begin
          cyc_cnt <= cyc_cnt + 1'b1;
        end
        default: begin // ARB_DONE, requester drops req now
          cpu.done <= 1'b0;
          dma.done <= 1'b0;
          state    <= ARB_IDLE;
        end
      endcase
    end
  end

  // Bus payload and per-requester read data
  always_ff @(posedge CLK) begin
    if (state == ARB_IDLE && (pick_cpu || pick_dma)) begin
      p_addr  <= pick_dma ? dma.addr : cpu.addr;
      p_wdata <= pick_dma ? dma.wdata : cpu.wdata;
    end
    if (last_cyc && !p_rd_n) begin
      if (owner_dma) dma.rdata <= p_rdata; // Sampled in the last strobe cycle
      else cpu.rdata <= p_rdata;
    end
  end

endmodule

/* dma_engine.sv */
`timescale 1ns/1ps

module dma_engine import sdmac_pkg::*; (
  input  logic            CLK,
  input  logic            CLR_FLUSHFIFO,
  input  logic            dmaena,
  input  logic            dmadir,      // 0 = SCSI to memory
  input  logic            scsi_drq,
  input  logic            fifo_empty,
  input  logic            fifo_full,
  input  logic [7:0]      fifo_rdata,
  output logic            fifo_wr,
  output logic            fifo_rd,
  output logic [7:0]      fifo_wdata,
  periph_req_if.requester bus
);

  dma_state_e state;
  logic       dir_q;      // Direction of the byte in flight
  logic       can_start;

  // Needs a request and room or data on the FIFO side
  assign can_start = dmaena && scsi_drq && (dmadir ? !fifo_empty : !fifo_full);
  assign bus.addr  = DATA_PORT; // Always the data register

  always_ff @(posedge CLK or negedge CLR_FLUSHFIFO) begin
    if (!CLR_FLUSHFIFO) begin
      state   <= DMA_IDLE;
      dir_q   <= 1'b0;
      bus.req <= 1'b0;
      bus.we  <= 1'b0;
      fifo_wr <= 1'b0;
      fifo_rd <= 1'b0;
    end else begin
      fifo_wr <= 1'b0;
      case (state)
        DMA_IDLE: if (can_start) begin
          dir_q <= dmadir;
          if (dmadir) begin
            fifo_rd <= 1'b1; // Fetch the byte first
            state   <= DMA_FIFO;
          end else begin
            bus.req <= 1'b1;
            bus.we  <= 1'b0;
            state   <= DMA_REQ;
          end
        end
        DMA_REQ: if (bus.done) begin
          bus.req <= 1'b0;
          if (dir_q) begin
            state <= DMA_IDLE; // Byte written to the chip
          end else begin
            fifo_wr <= 1'b1;
            state   <= DMA_FIFO;
          end
        end
        default: begin // DMA_FIFO
          if (!dir_q) begin
            state <= DMA_IDLE; // FIFO write pulse done
          end else if (fifo_rd) begin
            fifo_rd <= 1'b0;   // Data valid next cycle
          end else begin
            bus.req <= 1'b1;
            bus.we  <= 1'b1;
            state   <= DMA_REQ;
          end
        end
      endcase
    end
  end

  // Byte holding registers
  always_ff @(posedge CLK) begin
    if (state == DMA_REQ && bus.done && !dir_q) fifo_wdata <= bus.rdata;
    if (state == DMA_FIFO && dir_q && !fifo_rd) bus.wdata <= fifo_rdata;
  end

endmodule

/* sdmac_top.sv */
`timescale 1ns/1ps

module sdmac_top import sdmac_pkg::*; (
  input  logic        CLK,
  input  logic        CLR_FLUSHFIFO,
  // CPU bus
  input  logic [7:0]  addr,
  input  logic        dmac_n,
  input  logic        as_n,
  input  logic        rw,
  input  logic [31:0] mid,
  output logic [31:0] mod,
  output logic        reg_dsk_n,
  // SCSI chip bus
  output logic [4:0]  p_addr,
  output logic [7:0]  p_wdata,
  output logic        p_cs_n,
  output logic        p_rd_n,
  output logic        p_wr_n,
  input  logic [7:0]  p_rdata,
  // External FIFO
  input  logic        fifo_empty,
  input  logic        fifo_full,
  input  logic [7:0]  fifo_rdata,
  output logic        fifo_wr,
  output logic        fifo_rd,
  output logic [7:0]  fifo_wdata,
  input  logic        stop_flush,
  input  logic        scsi_int,
  input  logic        scsi_drq,
  output logic        preset,
  output logic        dmaena,
  output logic        dmadir,
  output logic        flushfifo,
  output logic        a1,
  output logic        int_n
);

  reg_sel_e          sel;
  logic              wr_stb;
  logic              rd_act;
  logic [CNTR_W-1:0] cntr;
  logic [ISTR_W-1:0] istr;

  periph_req_if cpu_bus ();  // CPU window requester
  periph_req_if dma_bus ();  // DMA engine requester

  addr_decoder u_addr_decoder (
    .CLK, .CLR_FLUSHFIFO, .addr, .dmac_n, .as_n, .rw,
    .mid_low (mid[7:0]),
    .sel, .wr_stb, .rd_act,
    .win     (cpu_bus),
    .reg_dsk_n
  );

  istr_reg u_istr_reg (
    .CLK, .CLR_FLUSHFIFO, .fifo_empty, .fifo_full, .scsi_int,
    .clr_int  (wr_stb && sel == SEL_CLR_INT),
    .dma_stop (wr_stb && sel == SEL_SP_DMA),  // Stop also flags E_INT
    .inten    (cntr[CNTR_INTEN]),
    .istr, .int_n
  );

  cntr_reg u_cntr_reg (
    .CLK, .CLR_FLUSHFIFO,
    .cntr_wr (wr_stb && sel == SEL_CNTR),
    .acr_wr  (wr_stb && sel == SEL_ACR),
    .st_dma  (wr_stb && sel == SEL_ST_DMA),
    .sp_dma  (wr_stb && sel == SEL_SP_DMA),
    .flush   (wr_stb && sel == SEL_FLUSH),
    .stop_flush,
    .mid     (mid[CNTR_W-1:0]),
    .mid_a1  (mid[25]),
    .cntr, .dmaena, .flushfifo, .a1
  );

  periph_arbiter u_periph_arbiter (
    .CLK, .CLR_FLUSHFIFO,
    .cpu (cpu_bus),
    .dma (dma_bus),
    .p_addr, .p_wdata, .p_cs_n, .p_rd_n, .p_wr_n, .p_rdata
  );

  dma_engine u_dma_engine (
    .CLK, .CLR_FLUSHFIFO, .dmaena, .dmadir, .scsi_drq, .fifo_empty, .fifo_full,
    .fifo_rdata, .fifo_wr, .fifo_rd, .fifo_wdata,
    .bus (dma_bus)
  );

  assign preset = cntr[CNTR_PRESET];
  assign dmadir = cntr[CNTR_DDIR];

  // CPU read data, zero outside a read cycle
  always_comb begin
    mod = '0;
    if (rd_act) begin
      case (sel)
        SEL_WTC:    mod = WTC_VALUE;
        SEL_CNTR:   mod = {{(32 - CNTR_W){1'b0}}, cntr};
        SEL_ISTR:   mod = {{(32 - ISTR_W){1'b0}}, istr};
        SEL_WINDOW: mod = {24'h0, cpu_bus.rdata}; // Byte from the SCSI chip
        default:    mod = '0;
      endcase
    end
  end

endmodule

/* sdmac_sva.sv */
`timescale 1ns/1ps

module sdmac_sva import sdmac_pkg::*; (
  input logic CLK,
  input logic CLR_FLUSHFIFO,
  input logic p_cs_n,
  input logic p_rd_n,
  input logic p_wr_n,
  input logic as_n,
  input logic reg_dsk_n,
  input logic cpu_done,
  input logic dma_done
);

  int fails = 0; // Assertion failures so far

  // Chip select spans one fixed peripheral cycle
  cs_len: assert property (@(posedge CLK) disable iff (!CLR_FLUSHFIFO)
    $fell(p_cs_n) |-> !p_cs_n [*P_CYCLE] ##1 p_cs_n)
    else begin
      fails++;
      $error("p_cs_n low for other than P_CYCLE cycles");
    end

  rd_wr_excl: assert property (@(posedge CLK) disable iff (!CLR_FLUSHFIFO)
    !(!p_rd_n && !p_wr_n))
    else begin
      fails++;
      $error("p_rd_n and p_wr_n low together");
    end

  done_excl: assert property (@(posedge CLK) disable iff (!CLR_FLUSHFIFO)
    !(cpu_done && dma_done))
    else begin
      fails++;
      $error("done to both requesters");
    end

  // No DSACK outside a CPU cycle
  dsk_idle: assert property (@(posedge CLK) disable iff (!CLR_FLUSHFIFO)
    as_n |-> reg_dsk_n)
    else begin
      fails++;
      $error("reg_dsk_n low while as_n high");
    end

endmodule

bind sdmac_top sdmac_sva u_sva (
  .CLK           (CLK),
  .CLR_FLUSHFIFO (CLR_FLUSHFIFO),
  .p_cs_n        (p_cs_n),
  .p_rd_n        (p_rd_n),
  .p_wr_n        (p_wr_n),
  .as_n          (as_n),
  .reg_dsk_n     (reg_dsk_n),
  .cpu_done      (cpu_bus.done),
  .dma_done      (dma_bus.done)
);

/* sdmac_checker.sv */
`timescale 1ns/1ps

module sdmac_checker import sdmac_pkg::*; (
  input logic        CLK,
  input logic        CLR_FLUSHFIFO,
  input logic [7:0]  addr,
  input logic        dmac_n,
  input logic        as_n,
  input logic        rw,
  input logic [31:0] mid,
  input logic [31:0] mod,
  input logic        reg_dsk_n,
  input logic [4:0]  p_addr,
  input logic [7:0]  p_wdata,
  input logic        p_cs_n,
  input logic        p_wr_n,
  input logic        fifo_empty,
  input logic        fifo_full,
  input logic        stop_flush,
  input logic        scsi_int,
  input logic        dmaena,
  input logic        flushfifo,
  input logic        a1,
  input logic        preset,
  input logic        dmadir,
  input logic        int_n
);

  int checks = 0;
  int errors = 0;
  int test_checks = 0;
  int test_errors = 0;

  // Reference state, rebuilt from what is seen on the ports
  logic [8:0] m_cntr;
  logic       m_ints, m_eint, m_dmaena, m_flush, m_a1;
  logic       as_prev;
  logic [7:0] pregs [0:31];  // SCSI registers written through the bus
  logic       pvalid [0:31];

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    test_checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic note_error(input string msg);
    checks++;
    test_checks++;
    errors++;
    test_errors++;
    $display("Error: %s", msg);
  endtask

  task automatic end_test(input string name);
    $display("Test %-10s %0d checks, %0d errors", name, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  function automatic logic int_expected();
    return m_cntr[CNTR_INTEN] & (m_ints | m_eint);
  endfunction

  function automatic logic [31:0] expected_read(input logic [7:0] a, input logic fe,
                                                input logic ff);
    logic [31:0] v;
    v = '0;
    if (a[7:5] == 3'b010) begin
      v = {24'h0, pregs[a[4:0]]};
    end else begin
      case (a)
        8'h04: v = 32'h4;            // WTC is fixed
        8'h08: v = {23'h0, m_cntr};
        8'h1C: begin
          v[8] = int_expected();
          v[7] = m_ints;
          v[6] = m_eint;
          v[1] = fe;                 // Live FIFO flags
          v[0] = ff;
        end
        default: v = '0;
      endcase
    end
    return v;
  endfunction

  // Model update on the strobes
  always @(posedge CLK or negedge CLR_FLUSHFIFO) begin
    if (!CLR_FLUSHFIFO) begin
      m_cntr = '0;
      {m_ints, m_eint, m_dmaena, m_flush, m_a1} = '0;
      as_prev = 1'b1;
      for (int i = 0; i < 32; i++) pvalid[i] = 1'b0;
    end else begin
      if (!as_n && !dmac_n && as_prev && addr[7:5] != 3'b010) begin
        case (addr)
          8'h08: if (!rw) m_cntr = mid[8:0];
          8'h0C: if (!rw) m_a1 = mid[25];
          8'h10: m_dmaena = 1'b1;
          8'h3C: begin
            m_dmaena = 1'b0;
            m_eint   = 1'b1;      // Stop flags end of DMA
          end
          8'h18: begin
            m_ints = 1'b0;
            m_eint = 1'b0;
          end
          8'h14: m_flush = 1'b1;
          default: ;
        endcase
      end
      if (scsi_int) m_ints = 1'b1;
      if (stop_flush) m_flush = 1'b0;
      if (!p_cs_n && !p_wr_n) begin
        pregs[p_addr]  = p_wdata;
        pvalid[p_addr] = 1'b1;
      end
      as_prev = as_n;
    end
  end

  // Compare once per CPU cycle, just after DSACK
  always @(negedge reg_dsk_n) begin
    #1;
    if (!as_n) begin
      if (rw) begin
        if (addr[7:5] == 3'b010 && !pvalid[addr[4:0]])
          note_error("window read of a SCSI register never written");
        else
          check_val("mod", mod, expected_read(addr, fifo_empty, fifo_full));
      end
      check_val("dmaena", dmaena, m_dmaena);
      check_val("flushfifo", flushfifo, m_flush);
      check_val("a1", a1, m_a1);
      check_val("preset", preset, m_cntr[CNTR_PRESET]);
      check_val("dmadir", dmadir, m_cntr[CNTR_DDIR]);
      check_val("int_n", int_n, !int_expected());
    end
  end

endmodule

/* tb_sdmac.sv */
`timescale 1ns/1ps

module tb_sdmac import sdmac_pkg::*; ();

  localparam int CPU_TIMEOUT = 200;
  localparam int DMA_TIMEOUT = 20000;
  localparam int NBYTES      = 24;

  logic        CLK, CLR_FLUSHFIFO;
  logic [7:0]  addr;
  logic        dmac_n, as_n, rw, stop_flush, scsi_int;
  logic [31:0] mid, mod;
  logic        reg_dsk_n, p_cs_n, p_rd_n, p_wr_n;
  logic [4:0]  p_addr;
  logic [7:0]  p_wdata, fifo_wdata;
  logic [7:0]  p_rdata = 8'h0;
  logic [7:0]  fifo_rdata = 8'h0;
  logic        fifo_empty = 1'b1;
  logic        fifo_full = 1'b0;
  logic        scsi_drq = 1'b0;
  logic        fifo_wr, fifo_rd, preset, dmaena, dmadir, flushfifo, a1, int_n;

  logic [31:0] lfsr = 32'hbe48;
  logic [7:0]  scsi_regs [0:31];
  logic [7:0]  src_q[$], sink_q[$], fifo_src[$], fifo_sink[$], exp_q[$];
  logic        p_seen = 1'b0;
  logic        load_on = 1'b0;   // Random DRQ and FIFO flags

  sdmac_top uut (.*);
  sdmac_checker chk (.*);

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic end_run(input bit timed_out);
    int errs;
    errs = chk.errors + uut.u_sva.fails;
    $display("Totals: %0d checks, %0d errors", chk.checks, errs);
    if (!timed_out && errs == 0) $display("Result: PASSED");
    else $display("Result: FAILED");
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout: %s", what);
    end_run(1'b1);
  endtask

  // One CPU cycle, started and left on a falling edge
  task automatic cpu_access(input logic [7:0] a, input logic rd, input logic [31:0] wd,
                            output logic [31:0] rdv);
    int n;
    n = 0;
    addr = a;
    rw = rd;
    mid = wd;
    dmac_n = 1'b0;
    as_n = 1'b0;
    do begin
      @(negedge CLK);
      n++;
      if (n > CPU_TIMEOUT) abort_on_timeout("no reg_dsk_n for a CPU cycle");
    end while (reg_dsk_n);
    rdv = mod;
    if (a[7:5] != 3'b010) chk.check_val("term_edges", n - 1, TERM_DELAY);
    as_n = 1'b1;
    dmac_n = 1'b1;
    rw = 1'b1;
    @(negedge CLK);
  endtask

  task automatic cpu_write(input logic [7:0] a, input logic [31:0] wd);
    logic [31:0] dummy;
    cpu_access(a, 1'b0, wd, dummy);
  endtask

  task automatic cpu_read(input logic [7:0] a, output logic [31:0] rdv);
    cpu_access(a, 1'b1, 32'h0, rdv);
  endtask

  task automatic window_check(input logic [4:0] pa);
    logic [7:0]  d;
    logic [31:0] v;
    d = 8'(rand_bits(8));
    cpu_write({3'b010, pa}, {24'h0, d});
    chk.check_val("scsi_reg", scsi_regs[pa], d);
    cpu_read({3'b010, pa}, v);  // Value compared by the checker
  endtask

  // SCSI chip, FIFO and load models, all on the falling edge
  always @(negedge CLK) begin
    if (p_cs_n) begin
      p_seen = 1'b0;
    end else if (!p_seen) begin
      p_seen = 1'b1;
      if (!p_rd_n && p_addr == DATA_PORT) begin
        if (src_q.size() > 0) p_rdata = src_q.pop_front();
        else chk.note_error("DATA_PORT read with no source byte left");
      end else if (!p_rd_n) begin
        p_rdata = scsi_regs[p_addr];
      end
      if (!p_wr_n && p_addr == DATA_PORT) sink_q.push_back(p_wdata);
      else if (!p_wr_n) scsi_regs[p_addr] = p_wdata;
    end
    if (fifo_wr) fifo_sink.push_back(fifo_wdata);
    if (fifo_rd) begin
      if (fifo_src.size() > 0) fifo_rdata = fifo_src.pop_front();
      else chk.note_error("FIFO read while the FIFO model is empty");
    end
    if (load_on) begin
      scsi_drq   = rand_bits(1) && (dmadir || src_q.size() > 0);
      fifo_full  = 1'(rand_bits(1));
      fifo_empty = (fifo_src.size() == 0) || rand_bits(1);
    end
  end

  initial begin
    logic [31:0] v;
    logic [31:0] w;
    logic [4:0]  pa;
    int          n;
    for (int i = 0; i < 32; i++) scsi_regs[i] = 8'h5a ^ 8'(i * 37);
    addr = 8'h0;
    dmac_n = 1'b1;
    as_n = 1'b1;
    rw = 1'b1;
    mid = 32'h0;
    stop_flush = 1'b0;
    scsi_int = 1'b0;
    CLR_FLUSHFIFO = 1'b0;
    repeat (16) @(negedge CLK);
    CLR_FLUSHFIFO = 1'b1;
    @(negedge CLK);

    chk.check_val("p_cs_n", p_cs_n, 1'b1);
    chk.check_val("p_rd_n", p_rd_n, 1'b1);
    chk.check_val("p_wr_n", p_wr_n, 1'b1);
    chk.check_val("reg_dsk_n", reg_dsk_n, 1'b1);
    chk.check_val("int_n", int_n, 1'b1);
    chk.check_val("dmaena", dmaena, 1'b0);
    chk.check_val("flushfifo", flushfifo, 1'b0);
    chk.check_val("fifo_wr", fifo_wr, 1'b0);
    chk.check_val("fifo_rd", fifo_rd, 1'b0);
    cpu_read(8'h08, v);
    cpu_read(8'h04, v);
    chk.end_test("reset");

    repeat (4) begin
      cpu_write(8'h08, rand_bits(32));
      cpu_read(8'h08, v);
    end
    for (int i = 0; i < 4; i++) begin
      fifo_empty = i[0];
      fifo_full  = i[1];
      cpu_read(8'h1C, v);
    end
    w = rand_bits(32);
    cpu_write(8'h0C, w);
    chk.check_val("a1", a1, w[25]);
    w = ~w;
    cpu_write(8'h0C, w);
    chk.check_val("a1", a1, w[25]);
    chk.end_test("registers");

    cpu_write(8'h10, 32'h0);     // Start DMA, DRQ stays low
    cpu_read(8'h1C, v);
    cpu_write(8'h3C, 32'h0);     // Stop DMA, sets E_INT
    cpu_read(8'h1C, v);
    cpu_write(8'h14, 32'h0);
    cpu_read(8'h1C, v);
    stop_flush = 1'b1;
    @(negedge CLK);
    stop_flush = 1'b0;
    cpu_read(8'h1C, v);
    cpu_write(8'h18, 32'h0);
    cpu_read(8'h1C, v);
    chk.end_test("strobes");

    cpu_write(8'h08, 32'h0);
    scsi_int = 1'b1;
    @(negedge CLK);
    scsi_int = 1'b0;
    cpu_read(8'h1C, v);
    chk.check_val("int_n", int_n, 1'b1);
    cpu_write(8'h08, 32'h4);     // Interrupt enable
    cpu_read(8'h1C, v);
    chk.check_val("int_n", int_n, 1'b0);
    cpu_write(8'h18, 32'h0);
    cpu_read(8'h1C, v);
    chk.check_val("int_n", int_n, 1'b1);
    chk.end_test("interrupts");

    repeat (6) begin
      pa = 5'(rand_bits(5));
      if (pa == DATA_PORT) pa = 5'h03;  // Data port feeds the DMA queues
      window_check(pa);
    end
    chk.end_test("window");

    // SCSI to memory under random load
    cpu_write(8'h08, 32'h0);
    exp_q.delete();
    repeat (NBYTES) exp_q.push_back(8'(rand_bits(8)));
    src_q = exp_q;
    load_on = 1'b1;
    cpu_write(8'h10, 32'h0);
    window_check(5'h07);
    n = 0;
    while (fifo_sink.size() < NBYTES) begin
      @(negedge CLK);
      n++;
      if (n > DMA_TIMEOUT) abort_on_timeout("SCSI to FIFO transfer stalled");
    end
    for (int i = 0; i < NBYTES; i++) chk.check_val("fifo_wdata", fifo_sink[i], exp_q[i]);
    cpu_write(8'h3C, 32'h0);
    load_on = 1'b0;
    scsi_drq = 1'b0;
    @(negedge CLK);

    // Memory to SCSI
    cpu_write(8'h08, 32'h2);
    exp_q.delete();
    repeat (NBYTES) exp_q.push_back(8'(rand_bits(8)));
    fifo_src = exp_q;
    load_on = 1'b1;
    cpu_write(8'h10, 32'h0);
    window_check(5'h12);
    n = 0;
    while (sink_q.size() < NBYTES) begin
      @(negedge CLK);
      n++;
      if (n > DMA_TIMEOUT) abort_on_timeout("FIFO to SCSI transfer stalled");
    end
    for (int i = 0; i < NBYTES; i++) chk.check_val("p_wdata", sink_q[i], exp_q[i]);
    cpu_write(8'h3C, 32'h0);
    load_on = 1'b0;
    scsi_drq = 1'b0;
    cpu_write(8'h18, 32'h0);
    cpu_read(8'h1C, v);
    chk.end_test("dma");

    end_run(1'b0);
  end

endmodule

/* files.f */
sdmac_pkg.sv
periph_req_if.sv
addr_decoder.sv
istr_reg.sv
cntr_reg.sv
periph_arbiter.sv
dma_engine.sv
sdmac_top.sv
sdmac_sva.sv
sdmac_checker.sv
tb_sdmac.sv
